// ==== build.f ====
verilog/host_endpoint_pkg.sv
verilog/neuron_model_pkg.sv
verilog/spindle_ifs.sv
verilog/trigger_param_bank.sv
verilog/waveform_fifo.sv
verilog/tick_timer.sv
verilog/sim_scheduler_fsm.sv
verilog/spindle_rate.sv
verilog/spike_integrator.sv
verilog/spindle_host_top.sv
verif/spindle_checker.sv
verif/spindle_assert.sv
verif/spindle_tb.sv

// ==== verif/spindle_assert.sv ====
module spindle_assert
#(
    parameter int FIFO_DEPTH = 8
)
(
    input logic ep50trig,
    input logic reset_global,
    input logic reset_sim,
    input logic pipe_write,
    input logic pipe_credit,
    input logic lce_valid,
    input logic ia_spike,
    input logic ii_spike
);
    timeunit 1ns;
    timeprecision 1ps;

    int occupancy;         // words in the FIFO as seen from the ports
    int assert_fails = 0;  // failed assertions so far

    always @(posedge ep50trig)
    begin
        if (reset_global || reset_sim)
            occupancy <= 0;
        else
            occupancy <= occupancy + int'(pipe_write) - int'(pipe_credit);
    end

    ////////////////////////////////////////////////////
    // flow control and pulse shape
    ////////////////////////////////////////////////////
    no_write_when_full: assert property (@(posedge ep50trig)
        disable iff (reset_global || reset_sim) pipe_write |-> occupancy < FIFO_DEPTH)
        else
        begin
            assert_fails++;
            $error("pipe write with a full FIFO");
        end

    credit_one_cycle: assert property (@(posedge ep50trig)
        disable iff (reset_global || reset_sim) pipe_credit |=> !pipe_credit)
        else
        begin
            assert_fails++;
            $error("pipe_credit high for more than one cycle");
        end

    valid_one_cycle: assert property (@(posedge ep50trig)
        disable iff (reset_global || reset_sim) lce_valid |=> !lce_valid)
        else
        begin
            assert_fails++;
            $error("lce_valid high for more than one cycle");
        end

    ia_spike_one_cycle: assert property (@(posedge ep50trig)
        disable iff (reset_global || reset_sim) ia_spike |=> !ia_spike)
        else
        begin
            assert_fails++;
            $error("ia_spike high for more than one cycle");
        end

    ii_spike_one_cycle: assert property (@(posedge ep50trig)
        disable iff (reset_global || reset_sim) ii_spike |=> !ii_spike)
        else
        begin
            assert_fails++;
            $error("ii_spike high for more than one cycle");
        end

    valid_after_credit: assert property (@(posedge ep50trig)
        disable iff (reset_global || reset_sim) pipe_credit |=> lce_valid)
        else
        begin
            assert_fails++;
            $error("lce_valid missing one cycle after pipe_credit");
        end

    valid_needs_credit: assert property (@(posedge ep50trig)
        disable iff (reset_global || reset_sim) lce_valid |-> $past(pipe_credit))
        else
        begin
            assert_fails++;
            $error("lce_valid without a pop in the previous cycle");
        end

endmodule

bind spindle_host_top spindle_assert #(.FIFO_DEPTH(FIFO_DEPTH)) u_assert
(
    .ep50trig     (ep50trig),
    .reset_global (reset_global),
    .reset_sim    (reset_sim),
    .pipe_write   (pipe_write),
    .pipe_credit  (pipe_credit),
    .lce_valid    (lce_valid),
    .ia_spike     (ia_spike),
    .ii_spike     (ii_spike)
);

// ==== verif/spindle_checker.sv ====
module spindle_checker
    import host_endpoint_pkg::*;
    import neuron_model_pkg::*;
#(
    parameter rate_t IA_THRESHOLD = 32'h0200_0000,
    parameter rate_t II_THRESHOLD = 32'h0200_0000
)
(
    input logic        ep50trig,
    input logic        reset_global,
    input logic        reset_sim,
    input logic [15:0] trig_strobe,
    input host_word_t  wire_in_data,
    input logic        pipe_write,
    input lce_t        pipe_data,
    input logic        pipe_credit,
    input lce_t        lce_out,
    input logic        lce_valid,
    input logic        ia_spike,
    input logic        ii_spike
);
    timeunit 1ns;
    timeprecision 1ps;

    string  test_name = "startup";
    int     error_count = 0;
    int     fault_count = 0;
    int     compared = 0;
    bit     armed = 1'b0;

    longint p_gd, p_gs, p_gi, p_gii, p_td;  // mirrored parameter bank
    longint cnt, ia_r, ii_r, ia_acc, ii_acc;
    int     st;                              // 0 idle 1 fetch 2 rate 3 integrate
    bit     tick_m, valid_m, ia_spk, ii_spk;
    longint lce_m;
    lce_t   q [$];                           // samples held in the FIFO

    task automatic fault(input string msg);
        $display("checker fault in %s: %s", test_name, msg);
        fault_count++;
    endtask

    task automatic check_value(input string what, input longint exp, input longint act);
        if (exp != act)
        begin
            $display("[ERROR] %s %s expected %0d actual %0d", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic report_counts(input int assert_fails);
        $display({"checker: %0d cycles compared, %0d value errors, %0d other faults, ",
                  "%0d assertion failures"},
                 compared, error_count, fault_count, assert_fails);
    endtask

    ////////////////////////////////////////////////////
    // cycle model, all terms from pre-edge values
    ////////////////////////////////////////////////////
    always @(posedge ep50trig)
    begin
        bit pop;
        if (reset_global || reset_sim)
        begin
            armed = 1'b1;
            q.delete();
            {cnt, ia_r, ii_r, ia_acc, ii_acc, lce_m} = '0;
            {tick_m, valid_m, ia_spk, ii_spk} = '0;
            st = 0;
        end
        else
        begin
            pop     = (st == 1) && (q.size() != 0);
            valid_m = pop;
            if (pop)
                lce_m = q.pop_front();
            ia_spk = 1'b0;
            ii_spk = 1'b0;
            if (st == 3)
            begin
                ia_acc += ia_r;
                ii_acc += ii_r;
                if (ia_acc >= IA_THRESHOLD)
                begin
                    ia_acc -= IA_THRESHOLD;
                    ia_spk = 1'b1;
                end
                if (ii_acc >= II_THRESHOLD)
                begin
                    ii_acc -= II_THRESHOLD;
                    ii_spk = 1'b1;
                end
            end
            if (st == 2)  // rate uses the held length from last cycle
            begin
                ia_r = ((lce_m * p_gi) >> RATE_SHIFT) + p_gd;
                ii_r = ((lce_m * p_gii) >> RATE_SHIFT) + p_gs;
            end
            if (st == 0)
                st = tick_m ? 1 : 0;
            else
                st = (st + 1) % 4;
            if (cnt == 0)
            begin
                cnt    = (p_td < 3) ? 3 : p_td;
                tick_m = 1'b1;
            end
            else
            begin
                cnt--;
                tick_m = 1'b0;
            end
            if (pipe_write)
                q.push_back(pipe_data);
        end
        if (reset_global)
        begin
            p_gd = RST_GAMMA_DYN;
            p_gs = RST_GAMMA_STA;
            p_gi = RST_GI;
            p_gii = RST_GII;
            p_td = RST_TICK_DELAY;
        end
        else
        begin
            if (trig_strobe[TRIG_GAMMA_DYN])   p_gd = wire_in_data;
            if (trig_strobe[TRIG_GAMMA_STA])   p_gs = wire_in_data;
            if (trig_strobe[TRIG_GI])          p_gi = wire_in_data;
            if (trig_strobe[TRIG_GII])         p_gii = wire_in_data;
            if (trig_strobe[TRIG_TICK_PERIOD]) p_td = wire_in_data;
        end
    end

    // outputs are settled mid-cycle
    always @(negedge ep50trig)
    begin
        if (armed)
        begin
            compared++;
            check_value("pipe_credit", (st == 1) && (q.size() != 0), pipe_credit);
            check_value("lce_valid", valid_m, lce_valid);
            check_value("lce_out", lce_m, lce_out);
            check_value("ia_spike", ia_spk, ia_spike);
            check_value("ii_spike", ii_spk, ii_spike);
        end
    end

endmodule

// ==== verif/spindle_tb.sv ====
module spindle_tb
    import host_endpoint_pkg::*;
    import neuron_model_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int    FIFO_DEPTH     = 8;
    localparam rate_t IA_THRESHOLD   = 32'h0200_0000;
    localparam rate_t II_THRESHOLD   = 32'h0200_0000;
    localparam int    CREDIT_TIMEOUT = 200;  // cycles
    localparam int    NUM_TESTS      = 7;

    typedef struct
    {
        string name;
        int    n_trig;
        int    trig_bit [4];
        int    trig_val [4];
        int    n_samples;
        bit    sim_reset;
        int    n_ticks;
    } test_entry_t;

    logic        ep50trig;
    logic        reset_global;
    logic        reset_sim;
    logic [15:0] trig_strobe;
    host_word_t  wire_in_data;
    logic        pipe_write;
    lce_t        pipe_data;
    logic        pipe_credit;
    lce_t        lce_out;
    logic        lce_valid;
    logic        ia_spike;
    logic        ii_spike;

    test_entry_t tests [NUM_TESTS];
    int          credits;
    int          cur_delay;  // effective tick delay

    spindle_host_top #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .IA_THRESHOLD (IA_THRESHOLD),
        .II_THRESHOLD (II_THRESHOLD)
    ) uut (.*);

    spindle_checker #(
        .IA_THRESHOLD (IA_THRESHOLD),
        .II_THRESHOLD (II_THRESHOLD)
    ) chk (.*);

    initial
    begin
        ep50trig = 1'b0;
        forever #50 ep50trig = ~ep50trig;
    end

    // credits come back one per pop
    always @(posedge ep50trig)
    begin
        if (!reset_global && !reset_sim && pipe_credit)
        begin
            credits++;
            if (credits > FIFO_DEPTH)
                chk.fault("more credits returned than words were sent");
        end
    end

    task automatic set_test(input int idx, input string name, input int n_samples,
                            input bit sim_reset, input int n_ticks);
        tests[idx].name      = name;
        tests[idx].n_trig    = 0;
        tests[idx].n_samples = n_samples;
        tests[idx].sim_reset = sim_reset;
        tests[idx].n_ticks   = n_ticks;
    endtask

    task automatic add_trig(input int idx, input int bit_pos, input int value);
        tests[idx].trig_bit[tests[idx].n_trig] = bit_pos;
        tests[idx].trig_val[tests[idx].n_trig] = value;
        tests[idx].n_trig++;
    endtask

    task automatic pulse_trigger(input int bit_pos, input int value);
        @(posedge ep50trig);
        trig_strobe  <= 16'(1) << bit_pos;
        wire_in_data <= host_word_t'(value);
        @(posedge ep50trig);
        trig_strobe  <= '0;
        if (bit_pos == TRIG_TICK_PERIOD)
            cur_delay = (value < 3) ? 3 : value;
    endtask

    task automatic send_samples(input int n);
        int gap;
        int waited;
        for (int i = 0; i < n; i++)
        begin
            gap = $urandom % 3;
            repeat (gap) @(posedge ep50trig);
            waited = 0;
            while (credits == 0 && waited < CREDIT_TIMEOUT)
            begin
                @(posedge ep50trig);
                waited++;
            end
            if (credits == 0)
            begin
                chk.fault("sender timed out waiting for a credit");
                return;
            end
            pipe_write <= 1'b1;
            pipe_data  <= lce_t'($urandom);
            credits--;
            @(posedge ep50trig);
            pipe_write <= 1'b0;
        end
    endtask

    initial
    begin
        trig_strobe  = '0;
        wire_in_data = '0;
        pipe_write   = 1'b0;
        pipe_data    = '0;
        reset_global = 1'b1;
        reset_sim    = 1'b1;
        credits      = FIFO_DEPTH;
        cur_delay    = RST_TICK_DELAY;
        void'($urandom(32'hd28b));

        set_test(0, "defaults", 12, 1'b0, 14);
        set_test(1, "order_and_credits", 20, 1'b0, 22);
        set_test(2, "param_triggers", 10, 1'b0, 12);
        add_trig(2, TRIG_GI, 40000);
        add_trig(2, TRIG_GII, 30000);
        add_trig(2, TRIG_GAMMA_DYN, 500);
        add_trig(2, TRIG_GAMMA_STA, 1000);
        set_test(3, "tick_period_20", 6, 1'b0, 8);
        add_trig(3, TRIG_TICK_PERIOD, 19);
        set_test(4, "tick_period_4", 6, 1'b0, 8);
        add_trig(4, TRIG_TICK_PERIOD, 1);
        set_test(5, "underrun", 3, 1'b0, 12);
        set_test(6, "sim_reset", 4, 1'b1, 10);

        repeat (10) @(posedge ep50trig);
        reset_global <= 1'b0;
        reset_sim    <= 1'b0;

        for (int t = 0; t < NUM_TESTS; t++)
        begin
            chk.test_name = tests[t].name;
            for (int k = 0; k < tests[t].n_trig; k++)
                pulse_trigger(tests[t].trig_bit[k], tests[t].trig_val[k]);
            if (tests[t].sim_reset)
            begin
                send_samples(FIFO_DEPTH);  // words left in the FIFO get flushed
                @(posedge ep50trig);
                reset_sim <= 1'b1;
                repeat (2) @(posedge ep50trig);
                reset_sim <= 1'b0;
                credits = FIFO_DEPTH;
            end
            fork
                send_samples(tests[t].n_samples);
                repeat (tests[t].n_ticks * (cur_delay + 1) + 10) @(posedge ep50trig);
            join
        end

        repeat (5) @(posedge ep50trig);
        chk.report_counts(uut.u_assert.assert_fails);
        if (chk.error_count + chk.fault_count + uut.u_assert.assert_fails == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== verilog/host_endpoint_pkg.sv ====
package host_endpoint_pkg;

    //////////////////////////////////////////////////
    // host data word
    //////////////////////////////////////////////////
    localparam int unsigned HOST_WORD_W = 16;

    typedef logic [HOST_WORD_W-1:0] host_word_t;

    //////////////////////////////////////////////////
    // trigger bit positions on trig_strobe
    //////////////////////////////////////////////////
    localparam int unsigned TRIG_GAMMA_DYN   = 4;   // dynamic fusimotor drive
    localparam int unsigned TRIG_GAMMA_STA   = 5;   // static fusimotor drive
    localparam int unsigned TRIG_TICK_PERIOD = 7;
    localparam int unsigned TRIG_GII         = 11;  // secondary gain
    localparam int unsigned TRIG_GI          = 12;  // primary gain

    //////////////////////////////////////////////////
    // values loaded by reset_global
    //////////////////////////////////////////////////
    localparam host_word_t RST_GAMMA_DYN  = 16'd80;
    localparam host_word_t RST_GAMMA_STA  = 16'd80;
    localparam host_word_t RST_GI         = 16'd20000;
    localparam host_word_t RST_GII        = 16'd7250;

    // 9 gives a tick every 10 cycles
    localparam host_word_t RST_TICK_DELAY = 16'd9;

endpackage

// ==== verilog/neuron_model_pkg.sv ====
package neuron_model_pkg;

    //////////////////////////////////////////////////
    // fixed-point widths
    //////////////////////////////////////////////////
    localparam int unsigned LCE_W  = 16;
    localparam int unsigned RATE_W = 32;

    typedef logic [LCE_W-1:0]  lce_t;   // unsigned muscle length
    typedef logic [RATE_W-1:0] rate_t;  // rate and accumulator

    // length * gain is scaled down by this before the offset is added
    localparam int unsigned RATE_SHIFT = 8;

    // shortest reload value of the tick counter, so one tick per 4 cycles
    localparam logic [15:0] MIN_TICK_DELAY = 16'd3;

    //////////////////////////////////////////////////
    // scheduler sequence, one step per cycle
    //////////////////////////////////////////////////
    typedef enum logic [1:0]
    {
        IDLE      = 2'd0,  // wait for tick
        FETCH     = 2'd1,  // pop one sample
        RATE      = 2'd2,  // register rates
        INTEGRATE = 2'd3   // step both neurons
    } sched_state_t;

endpackage

// ==== verilog/sim_scheduler_fsm.sv ====
module sim_scheduler_fsm
    import neuron_model_pkg::*;
(
    input  logic    ep50trig,
    input  logic    reset_sim,
    input  logic    reset_global,
    input  logic    tick,
    sample_if.sched samples,
    output lce_t    lce,
    output logic    lce_valid,
    output logic    rate_en,
    output logic    int_en
);

    sched_state_t state;
    sched_state_t state_next;
    logic         take;

    assign take        = (state == FETCH) && !samples.empty;
    assign samples.pop = take;
    assign rate_en     = (state == RATE);
    assign int_en      = (state == INTEGRATE);

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////
    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
                if (tick)
                    state_next = FETCH;
            FETCH:     state_next = RATE;       // empty fifo still steps on
            RATE:      state_next = INTEGRATE;
            INTEGRATE: state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // state and held length sample
    //////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global || reset_sim)
        begin
            state     <= IDLE;
            lce       <= '0;
            lce_valid <= 1'b0;
        end
        else
        begin
            state     <= state_next;
            lce_valid <= take;
            // underrun keeps the last length
            if (take)
                lce <= samples.head;
        end
    end

endmodule

// ==== verilog/spike_integrator.sv ====
module spike_integrator
    import neuron_model_pkg::*;
#(
    parameter rate_t THRESHOLD = 32'h0200_0000
)
(
    input  logic  ep50trig,
    input  logic  reset_sim,
    input  logic  reset_global,
    input  logic  int_en,
    input  rate_t rate,
    output logic  spike
);

    rate_t acc;
    rate_t sum;

    // acc stays below THRESHOLD, so no overflow here
    assign sum = acc + rate;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global || reset_sim)
        begin
            acc   <= '0;
            spike <= 1'b0;
        end
        else if (int_en && (sum >= THRESHOLD))
        begin
            acc   <= sum - THRESHOLD;  // keep the remainder
            spike <= 1'b1;
        end
        else
        begin
            if (int_en)
                acc <= sum;
            spike <= 1'b0;
        end
    end

endmodule

// ==== verilog/spindle_host_top.sv ====
module spindle_host_top
    import host_endpoint_pkg::*;
    import neuron_model_pkg::*;
#(
    parameter int    FIFO_DEPTH   = 8,
    parameter rate_t IA_THRESHOLD = 32'h0200_0000,
    parameter rate_t II_THRESHOLD = 32'h0200_0000
)
(
    input  logic        ep50trig,
    input  logic        reset_global,
    input  logic        reset_sim,
    input  logic [15:0] trig_strobe,
    input  host_word_t  wire_in_data,
    input  logic        pipe_write,
    input  lce_t        pipe_data,
    output logic        pipe_credit,
    output lce_t        lce_out,
    output logic        lce_valid,
    output logic        ia_spike,
    output logic        ii_spike
);

    host_word_t tick_delay;
    logic       tick;
    logic       rate_en;
    logic       int_en;
    rate_t      ia_rate;
    rate_t      ii_rate;

    param_if  params ();
    sample_if samples ();

    //////////////////////////////////////////////////
    // host side
    //////////////////////////////////////////////////
    trigger_param_bank u_param_bank
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),  // reset_sim keeps loaded params
        .trig_strobe  (trig_strobe),
        .wire_in_data (wire_in_data),
        .params       (params.source),
        .tick_delay   (tick_delay)
    );

    waveform_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo
    (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .reset_global (reset_global),
        .pipe_write   (pipe_write),
        .pipe_data    (pipe_data),
        .pipe_credit  (pipe_credit),
        .samples      (samples.fifo)
    );

    //////////////////////////////////////////////////
    // simulation step
    //////////////////////////////////////////////////
    tick_timer u_timer
    (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .reset_global (reset_global),
        .tick_delay   (tick_delay),
        .tick         (tick)
    );

    sim_scheduler_fsm u_sched
    (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .reset_global (reset_global),
        .tick         (tick),
        .samples      (samples.sched),
        .lce          (lce_out),
        .lce_valid    (lce_valid),
        .rate_en      (rate_en),
        .int_en       (int_en)
    );

    spindle_rate u_rate
    (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .reset_global (reset_global),
        .rate_en      (rate_en),
        .lce          (lce_out),
        .params       (params.sink),
        .ia_rate      (ia_rate),
        .ii_rate      (ii_rate)
    );

    // primary and secondary afferent neurons
    spike_integrator #(.THRESHOLD(IA_THRESHOLD)) ia_neuron
    (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .reset_global (reset_global),
        .int_en       (int_en),
        .rate         (ia_rate),
        .spike        (ia_spike)
    );

    spike_integrator #(.THRESHOLD(II_THRESHOLD)) ii_neuron
    (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .reset_global (reset_global),
        .int_en       (int_en),
        .rate         (ii_rate),
        .spike        (ii_spike)
    );

endmodule

// ==== verilog/spindle_ifs.sv ====
// gains and fusimotor drives from the parameter bank
interface param_if
    import host_endpoint_pkg::*;
();
    host_word_t gamma_dyn;
    host_word_t gamma_sta;
    host_word_t gi;
    host_word_t gii;

    modport source
    (
        output gamma_dyn,
        output gamma_sta,
        output gi,
        output gii
    );

    modport sink
    (
        input gamma_dyn,
        input gamma_sta,
        input gi,
        input gii
    );
endinterface

// FIFO head toward the scheduler, fall-through
interface sample_if
    import neuron_model_pkg::*;
();
    logic empty;
    lce_t head;
    logic pop;   // ignored while empty

    modport fifo
    (
        output empty,
        output head,
        input  pop
    );

    modport sched
    (
        input  empty,
        input  head,
        output pop
    );
endinterface

// ==== verilog/spindle_rate.sv ====
module spindle_rate
    import host_endpoint_pkg::*;
    import neuron_model_pkg::*;
(
    input  logic   ep50trig,
    input  logic   reset_sim,
    input  logic   reset_global,
    input  logic   rate_en,
    input  lce_t   lce,
    param_if.sink  params,
    output rate_t  ia_rate,
    output rate_t  ii_rate
);

    // linear stand-in for the bag/chain model
    function automatic rate_t rate_law
    (
        input lce_t       len,
        input host_word_t gain,
        input host_word_t offset
    );
        rate_t prod;
        prod = rate_t'(len) * rate_t'(gain);  // 16x16 fits in 32
        return (prod >> RATE_SHIFT) + rate_t'(offset);
    endfunction

    //////////////////////////////////////////////////
    // Ia from gi and gamma_dyn, II from gii and gamma_sta
    //////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global || reset_sim)
        begin
            ia_rate <= '0;
            ii_rate <= '0;
        end
        else if (rate_en)
        begin
            ia_rate <= rate_law(lce, params.gi, params.gamma_dyn);
            ii_rate <= rate_law(lce, params.gii, params.gamma_sta);
        end
    end

endmodule

// ==== verilog/tick_timer.sv ====
module tick_timer
    import host_endpoint_pkg::*;
    import neuron_model_pkg::*;
(
    input  logic       ep50trig,
    input  logic       reset_sim,
    input  logic       reset_global,
    input  host_word_t tick_delay,
    output logic       tick
);

    host_word_t cnt;
    host_word_t delay_eff;

    // short delays would let a tick land mid-sequence
    assign delay_eff = (tick_delay < MIN_TICK_DELAY) ? MIN_TICK_DELAY : tick_delay;

    //////////////////////////////////////////////////
    // down-counter, period delay_eff + 1
    //////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global || reset_sim)
        begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt  <= delay_eff;  // new delay picked up here only
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

// ==== verilog/trigger_param_bank.sv ====
module trigger_param_bank
    import host_endpoint_pkg::*;
(
    input  logic         ep50trig,
    input  logic         reset_global,
    input  logic [15:0]  trig_strobe,
    input  host_word_t   wire_in_data,
    param_if.source      params,
    output host_word_t   tick_delay
);

    host_word_t gamma_dyn_q;
    host_word_t gamma_sta_q;
    host_word_t gi_q;
    host_word_t gii_q;
    host_word_t tick_delay_q;

    //////////////////////////////////////////////////
    // one register per trigger bit
    //////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            gamma_dyn_q  <= RST_GAMMA_DYN;
            gamma_sta_q  <= RST_GAMMA_STA;
            gi_q         <= RST_GI;
            gii_q        <= RST_GII;
            tick_delay_q <= RST_TICK_DELAY;
        end
        else
        begin
            // several bits in one pulse all load the same word
            if (trig_strobe[TRIG_GAMMA_DYN])
                gamma_dyn_q <= wire_in_data;
            if (trig_strobe[TRIG_GAMMA_STA])
                gamma_sta_q <= wire_in_data;
            if (trig_strobe[TRIG_GI])
                gi_q <= wire_in_data;
            if (trig_strobe[TRIG_GII])
                gii_q <= wire_in_data;
            if (trig_strobe[TRIG_TICK_PERIOD])
                tick_delay_q <= wire_in_data;  // used at next timer wrap
        end
    end

    assign params.gamma_dyn = gamma_dyn_q;
    assign params.gamma_sta = gamma_sta_q;
    assign params.gi        = gi_q;
    assign params.gii       = gii_q;
    assign tick_delay       = tick_delay_q;

endmodule

// ==== verilog/waveform_fifo.sv ====
module waveform_fifo
    import neuron_model_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
)
(
    input  logic    ep50trig,
    input  logic    reset_sim,
    input  logic    reset_global,
    input  logic    pipe_write,   // sender holds a credit
    input  lce_t    pipe_data,
    output logic    pipe_credit,
    sample_if.fifo  samples
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    lce_t             mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    // wrap without relying on a power-of-two depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_pop        = samples.pop && !samples.empty;
    assign pipe_credit   = do_pop;  // one credit back per pop
    assign samples.empty = (count == '0);
    assign samples.head  = mem[rd_ptr];

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (pipe_write)
            mem[wr_ptr] <= pipe_data;
    end

    //////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global || reset_sim)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (pipe_write)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({pipe_write, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push and pop together
            endcase
        end
    end

endmodule
